/* i2c_target.f */
+incdir+include
source/i2c_target_pkg.sv
source/i2c_glitch_filter.sv
source/i2c_bus_monitor.sv
source/i2c_bit_counter.sv
source/i2c_write_buffer.sv
source/i2c_target_fsm.sv
source/i2c_target_top.sv
tb/i2c_target_props.sv
tb/i2c_target_tb.sv

/* include/i2c_target_settings.svh */
// shared sizing for the I2C write target
// filter length is in clk cycles, so the clk must run well above the SCL rate
// address and byte widths follow the I2C standard and are not meant to change
`ifndef I2C_TARGET_SETTINGS_SVH
`define I2C_TARGET_SETTINGS_SVH

// equal samples needed before a filtered line follows its pin
`define I2C_FILTER_LEN 4

// 7-bit target addressing only
`define I2C_ADDR_W 7

// one data byte on the bus
`define I2C_BYTE_W 8

// enough to count the bits of one byte
`define I2C_BITCNT_W 3

`endif

/* source/i2c_bit_counter.sv */
// bit down-counter for one address or data byte
// load sets the count to byte width minus one
// load wins if both commands arrive together
`default_nettype none

`include "i2c_target_settings.svh"

module i2c_bit_counter (
    input  wire  clk,
    input  wire  rst,
    input  wire  cnt_load,
    input  wire  cnt_dec,
    output wire  cnt_zero
);

    i2c_target_pkg::bitcnt_t cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt_load) begin
            // seven more bits follow the current one
            cnt <= i2c_target_pkg::bitcnt_t'(`I2C_BYTE_W - 1);
        end else if (cnt_dec) begin
            cnt <= cnt - 1'b1;
        end
    end

    // last bit of the byte is the one sampled at zero
    assign cnt_zero = (cnt == '0);

endmodule

`default_nettype wire

/* source/i2c_bus_monitor.sv */
// filters SCL and SDA and reports edges and bus conditions
// all pulses are one clk wide and registered
// bus_active also tracks traffic addressed to other targets
`default_nettype none

module i2c_bus_monitor (
    input  wire  clk,
    input  wire  rst,
    input  wire  scl_i,
    input  wire  sda_i,
    output wire  sda_level,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_cond,
    output logic stop_cond,
    output logic bus_active
);

    logic scl_lvl;
    logic sda_lvl;
    logic scl_last;
    logic sda_last;
    logic start_det;
    logic stop_det;

    i2c_glitch_filter scl_filter_inst (
        .clk   (clk),
        .rst   (rst),
        .line  (scl_i),
        .level (scl_lvl)
    );

    i2c_glitch_filter sda_filter_inst (
        .clk   (clk),
        .rst   (rst),
        .line  (sda_i),
        .level (sda_lvl)
    );

    assign sda_level = sda_lvl;

    // SDA moving while SCL is high marks a condition
    assign start_det = sda_last && !sda_lvl && scl_lvl;
    assign stop_det  = !sda_last && sda_lvl && scl_lvl;

    always_ff @(posedge clk) begin
        if (rst) begin
            scl_last   <= 1'b1;
            sda_last   <= 1'b1;
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_cond <= 1'b0;
            stop_cond  <= 1'b0;
            bus_active <= 1'b0;
        end else begin
            scl_last   <= scl_lvl;
            sda_last   <= sda_lvl;
            scl_rise   <= scl_lvl && !scl_last;
            scl_fall   <= !scl_lvl && scl_last;
            start_cond <= start_det;
            stop_cond  <= stop_det;
            // busy from any start until the matching stop
            if (start_det) begin
                bus_active <= 1'b1;
            end else if (stop_det) begin
                bus_active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/i2c_glitch_filter.sv */
// run-length filter for one open-drain bus line
// output follows only after I2C_FILTER_LEN equal samples in a row
// the line is taken as already synchronous to clk
`default_nettype none

`include "i2c_target_settings.svh"

module i2c_glitch_filter (
    input  wire  clk,
    input  wire  rst,
    input  wire  line,
    output logic level
);

    // newest sample sits in bit 0
    logic [`I2C_FILTER_LEN-1:0] hist;

    always_ff @(posedge clk) begin
        if (rst) begin
            // idle bus floats high
            hist  <= {`I2C_FILTER_LEN{1'b1}};
            level <= 1'b1;
        end else begin
            hist <= {hist[`I2C_FILTER_LEN-2:0], line};
            // change only on a full run of equal samples
            if (hist == {`I2C_FILTER_LEN{1'b1}}) begin
                level <= 1'b1;
            end else if (hist == {`I2C_FILTER_LEN{1'b0}}) begin
                level <= 1'b0;
            end
            // mixed history keeps the old level
        end
    end

endmodule

`default_nettype wire

/* source/i2c_target_fsm.sv */
// write-only I2C target protocol FSM
// read requests are not acknowledged and the FSM drops back to idle
// SCL is held low after an ACK while the output byte is unaccepted
// scl_o and sda_o are open-drain levels, high means released
`default_nettype none

module i2c_target_fsm (
    input  wire  clk,
    input  wire  rst,
    input  wire  scl_rise,
    input  wire  scl_fall,
    input  wire  start_cond,
    input  wire  stop_cond,
    input  wire  sda_level,
    input  wire  cnt_zero,
    input  wire  addr_match,
    input  wire  out_full,
    output logic cnt_load,
    output logic cnt_dec,
    output logic shift_bit,
    output logic capture_addr,
    output logic stage_byte,
    output logic publish,
    output logic flush,
    output logic scl_o,
    output logic sda_o,
    output logic busy,
    output logic bus_addressed
);

    i2c_target_pkg::tgt_state_t state_q;
    i2c_target_pkg::tgt_state_t state_next;
    logic scl_o_next;
    logic sda_o_next;
    logic addressed_next;

    always_comb begin
        state_next     = state_q;
        scl_o_next     = scl_o;
        sda_o_next     = sda_o;
        addressed_next = bus_addressed;
        cnt_load       = 1'b0;
        cnt_dec        = 1'b0;
        shift_bit      = 1'b0;
        capture_addr   = 1'b0;
        stage_byte     = 1'b0;
        publish        = 1'b0;
        flush          = 1'b0;

        if (start_cond) begin
            // start or repeated start, close out the previous write
            flush          = 1'b1;
            cnt_load       = 1'b1;
            addressed_next = 1'b0;
            scl_o_next     = 1'b1;
            sda_o_next     = 1'b1;
            state_next     = i2c_target_pkg::st_address;
        end else if (stop_cond) begin
            flush          = 1'b1;
            addressed_next = 1'b0;
            scl_o_next     = 1'b1;
            sda_o_next     = 1'b1;
            state_next     = i2c_target_pkg::st_idle;
        end else begin
            case (state_q)
                i2c_target_pkg::st_idle: begin
                    addressed_next = 1'b0;
                end
                i2c_target_pkg::st_address: begin
                    if (scl_rise) begin
                        if (!cnt_zero) begin
                            // address bits, msb first
                            shift_bit = 1'b1;
                            cnt_dec   = 1'b1;
                        end else if (addr_match && !sda_level) begin
                            // 8th bit is R/W, low means write
                            capture_addr   = 1'b1;
                            addressed_next = 1'b1;
                            state_next     = i2c_target_pkg::st_ack;
                        end else begin
                            // other target or read, stay off the bus
                            state_next = i2c_target_pkg::st_idle;
                        end
                    end
                end
                i2c_target_pkg::st_ack: begin
                    // drive ACK once the master drops SCL after bit 8
                    if (scl_fall) begin
                        sda_o_next = 1'b0;
                        cnt_load   = 1'b1;
                        state_next = i2c_target_pkg::st_write_release;
                    end
                end
                i2c_target_pkg::st_write_release: begin
                    // end of ACK clock, or re-check while stretching
                    if (scl_fall || !scl_o) begin
                        sda_o_next = 1'b1;
                        if (out_full) begin
                            // previous byte still waiting downstream
                            scl_o_next = 1'b0;
                        end else begin
                            scl_o_next = 1'b1;
                            stage_byte = 1'b1;
                            state_next = i2c_target_pkg::st_write_shift;
                        end
                    end
                end
                i2c_target_pkg::st_write_shift: begin
                    if (scl_rise) begin
                        shift_bit = 1'b1;
                        if (!cnt_zero) begin
                            cnt_dec = 1'b1;
                        end else begin
                            // byte done, so the staged one was not last
                            publish    = 1'b1;
                            state_next = i2c_target_pkg::st_ack;
                        end
                    end
                end
                default: begin
                    state_next = i2c_target_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= i2c_target_pkg::st_idle;
            scl_o         <= 1'b1;
            sda_o         <= 1'b1;
            busy          <= 1'b0;
            bus_addressed <= 1'b0;
        end else begin
            state_q       <= state_next;
            scl_o         <= scl_o_next;
            sda_o         <= sda_o_next;
            bus_addressed <= addressed_next;
            // one cycle behind the state
            busy          <= (state_q != i2c_target_pkg::st_idle);
        end
    end

endmodule

`default_nettype wire

/* source/i2c_target_pkg.sv */
// types shared by the I2C write target blocks
// widths come from the settings header
`default_nettype none

`include "i2c_target_settings.svh"

package i2c_target_pkg;

    // bus address as seen after the start condition
    typedef logic [`I2C_ADDR_W-1:0] addr_t;

    // received data byte
    typedef logic [`I2C_BYTE_W-1:0] byte_t;

    // remaining bits in the current byte
    typedef logic [`I2C_BITCNT_W-1:0] bitcnt_t;

    // protocol states, write direction only
    typedef enum logic [2:0] {
        st_idle          = 3'd0,
        st_address       = 3'd1,
        st_ack           = 3'd2,
        st_write_release = 3'd3,
        st_write_shift   = 3'd4
    } tgt_state_t;

endpackage

`default_nettype wire

/* source/i2c_target_top.sv */
// I2C write target with a valid/ready byte output
// scl_i and sda_i must carry the wired-AND bus level, never scl_o or sda_o alone
// scl_o and sda_o are open-drain levels, high means released
`default_nettype none

module i2c_target_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          scl_i,
    output wire                          scl_o,
    input  wire                          sda_i,
    output wire                          sda_o,
    output wire  i2c_target_pkg::byte_t  m_data,
    output wire                          m_valid,
    input  wire                          m_ready,
    output wire                          m_last,
    output wire                          busy,
    output wire  i2c_target_pkg::addr_t  bus_address,
    output wire                          bus_addressed,
    output wire                          bus_active,
    input  wire                          enable,
    input  wire  i2c_target_pkg::addr_t  device_address,
    input  wire  i2c_target_pkg::addr_t  device_address_mask
);

    // monitor events
    logic sda_level;
    logic scl_rise;
    logic scl_fall;
    logic start_cond;
    logic stop_cond;

    // counter handshake
    logic cnt_load;
    logic cnt_dec;
    logic cnt_zero;

    // buffer commands and status
    logic shift_bit;
    logic capture_addr;
    logic stage_byte;
    logic publish;
    logic flush;
    logic addr_match;
    logic out_full;

    i2c_bus_monitor i2c_bus_monitor_inst (
        .clk        (clk),
        .rst        (rst),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .sda_level  (sda_level),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_cond (start_cond),
        .stop_cond  (stop_cond),
        .bus_active (bus_active)
    );

    i2c_bit_counter i2c_bit_counter_inst (
        .clk      (clk),
        .rst      (rst),
        .cnt_load (cnt_load),
        .cnt_dec  (cnt_dec),
        .cnt_zero (cnt_zero)
    );

    i2c_write_buffer i2c_write_buffer_inst (
        .clk                 (clk),
        .rst                 (rst),
        .sda_level           (sda_level),
        .shift_bit           (shift_bit),
        .capture_addr        (capture_addr),
        .stage_byte          (stage_byte),
        .publish             (publish),
        .flush               (flush),
        .enable              (enable),
        .device_address      (device_address),
        .device_address_mask (device_address_mask),
        .addr_match          (addr_match),
        .out_full            (out_full),
        .bus_address         (bus_address),
        .m_data              (m_data),
        .m_valid             (m_valid),
        .m_ready             (m_ready),
        .m_last              (m_last)
    );

    i2c_target_fsm i2c_target_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .start_cond    (start_cond),
        .stop_cond     (stop_cond),
        .sda_level     (sda_level),
        .cnt_zero      (cnt_zero),
        .addr_match    (addr_match),
        .out_full      (out_full),
        .cnt_load      (cnt_load),
        .cnt_dec       (cnt_dec),
        .shift_bit     (shift_bit),
        .capture_addr  (capture_addr),
        .stage_byte    (stage_byte),
        .publish       (publish),
        .flush         (flush),
        .scl_o         (scl_o),
        .sda_o         (sda_o),
        .busy          (busy),
        .bus_addressed (bus_addressed)
    );

endmodule

`default_nettype wire

/* source/i2c_write_buffer.sv */
// receive shift register, address compare and output stage
// bytes leave one byte time late so the final one can carry m_last
// m_data is only rewritten while the output is empty or being taken
`default_nettype none

`include "i2c_target_settings.svh"

module i2c_write_buffer (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           sda_level,
    input  wire                           shift_bit,
    input  wire                           capture_addr,
    input  wire                           stage_byte,
    input  wire                           publish,
    input  wire                           flush,
    input  wire                           enable,
    input  wire  i2c_target_pkg::addr_t   device_address,
    input  wire  i2c_target_pkg::addr_t   device_address_mask,
    output wire                           addr_match,
    output wire                           out_full,
    output i2c_target_pkg::addr_t         bus_address,
    output i2c_target_pkg::byte_t         m_data,
    output logic                          m_valid,
    input  wire                           m_ready,
    output logic                          m_last
);

    i2c_target_pkg::byte_t shift_q;
    // full byte sitting in shift_q
    logic byte_done;
    // byte in m_data not yet offered
    logic pending;

    // only masked bits take part in the compare
    assign addr_match = enable &&
        (((shift_q[`I2C_ADDR_W-1:0] ^ device_address) & device_address_mask) == '0);

    assign out_full = m_valid && !m_ready;

    always_ff @(posedge clk) begin
        if (shift_bit) begin
            shift_q <= {shift_q[`I2C_BYTE_W-2:0], sda_level};
        end
        if (capture_addr) begin
            bus_address <= shift_q[`I2C_ADDR_W-1:0];
        end
        if (stage_byte && byte_done) begin
            m_data <= shift_q;
            m_last <= 1'b0;
        end
        // transaction ended with a byte held back
        if (flush && pending) begin
            m_last <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_done <= 1'b0;
            pending   <= 1'b0;
            m_valid   <= 1'b0;
        end else begin
            if ((publish || flush) && pending) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end

            if (flush) begin
                byte_done <= 1'b0;
                pending   <= 1'b0;
            end else if (publish) begin
                byte_done <= 1'b1;
                pending   <= 1'b0;
            end else if (stage_byte) begin
                // nothing staged right after the address
                byte_done <= 1'b0;
                pending   <= byte_done;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/i2c_target_props.sv */
// concurrent checks on the I2C target top level, attached with bind
// observes ports only and drives nothing
`default_nettype none

module i2c_target_props (
    input wire                         clk,
    input wire                         rst,
    input wire                         scl_o,
    input wire                         sda_o,
    input wire i2c_target_pkg::byte_t  m_data,
    input wire                         m_valid,
    input wire                         m_ready,
    input wire                         m_last,
    input wire                         bus_addressed
);

    // stretching only inside an addressed write
    scl_low_addressed: assert property (@(posedge clk) disable iff (rst)
        !scl_o |-> bus_addressed)
        else $error("scl_o held low while the target is not addressed");

    // held byte must not change under back-pressure
    data_stable: assert property (@(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> ($stable(m_data) && $stable(m_last)))
        else $error("m_data or m_last changed while waiting for m_ready");

    // no ACK drive unless this target was selected
    sda_released: assert property (@(posedge clk) disable iff (rst)
        !bus_addressed |-> sda_o)
        else $error("sda_o driven low while the target is not addressed");

    // output stage comes out of reset empty
    valid_after_reset: assert property (@(posedge clk)
        rst |=> !m_valid)
        else $error("m_valid high in the cycle after reset");

endmodule

bind i2c_target_top i2c_target_props i2c_target_props_inst (
    .clk           (clk),
    .rst           (rst),
    .scl_o         (scl_o),
    .sda_o         (sda_o),
    .m_data        (m_data),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .m_last        (m_last),
    .bus_addressed (bus_addressed)
);

`default_nettype wire

/* tb/i2c_target_tb.sv */
// testbench for the I2C write target
// master model runs 40 clk per SCL bit and honors clock stretching
// DUT sees only the wired-AND of master drive and target drive
`default_nettype none

module i2c_target_tb;

    localparam int NUM_TESTS   = 8;
    localparam int HALF        = 20;
    localparam int QUART       = 10;
    // stalls beyond the ACK clock force the target to stretch
    localparam int STRETCH_MIN = 4 * HALF;

    logic clk;
    logic rst;
    logic scl_m;
    logic sda_m;
    logic m_ready;
    logic enable;
    i2c_target_pkg::addr_t device_address;
    i2c_target_pkg::addr_t device_address_mask;

    wire scl_o;
    wire sda_o;
    wire m_valid;
    wire m_last;
    wire busy;
    wire bus_addressed;
    wire bus_active;
    i2c_target_pkg::byte_t m_data;
    i2c_target_pkg::addr_t bus_address;

    // open-drain bus lines
    wire scl_bus = scl_m & scl_o;
    wire sda_bus = sda_m & sda_o;

    // transaction table
    string                 t_name  [NUM_TESTS];
    i2c_target_pkg::addr_t t_addr  [NUM_TESTS];
    logic                  t_rw    [NUM_TESTS];
    logic                  t_en    [NUM_TESTS];
    i2c_target_pkg::addr_t t_dev   [NUM_TESTS];
    i2c_target_pkg::addr_t t_mask  [NUM_TESTS];
    int                    t_bytes [NUM_TESTS];
    logic                  t_rs    [NUM_TESTS];
    int                    t_stall [NUM_TESTS];
    logic                  t_ack   [NUM_TESTS];

    // {last, data} in stream order
    logic [8:0] exp_q[$];
    string cur_name;
    int cur_stall;
    int stretch_cycles;
    int cycles;
    int limit;

    always #5 clk = ~clk;

    i2c_target_top i2c_target_top_inst (
        .clk                 (clk),
        .rst                 (rst),
        .scl_i               (scl_bus),
        .scl_o               (scl_o),
        .sda_i               (sda_bus),
        .sda_o               (sda_o),
        .m_data              (m_data),
        .m_valid             (m_valid),
        .m_ready             (m_ready),
        .m_last              (m_last),
        .busy                (busy),
        .bus_address         (bus_address),
        .bus_addressed       (bus_addressed),
        .bus_active          (bus_active),
        .enable              (enable),
        .device_address      (device_address),
        .device_address_mask (device_address_mask)
    );

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %0h actual %0h", cur_name, what, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run exceeded %0d cycles during %s", limit, cur_name);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic add_test(input int idx, input string name, input logic [6:0] addr,
                            input logic rw, input logic en, input logic [6:0] dev,
                            input logic [6:0] mask, input int nbytes, input logic rs,
                            input int stall, input logic ack);
        t_name[idx]  = name;
        t_addr[idx]  = addr;
        t_rw[idx]    = rw;
        t_en[idx]    = en;
        t_dev[idx]   = dev;
        t_mask[idx]  = mask;
        t_bytes[idx] = nbytes;
        t_rs[idx]    = rs;
        t_stall[idx] = stall;
        t_ack[idx]   = ack;
    endtask

    task automatic load_table();
        // idx name addr rw en dev mask bytes rs stall ack
        add_test(0, "basic write", 7'h42, 1'b0, 1'b1, 7'h42, 7'h7f, 3, 1'b0, 0, 1'b1);
        add_test(1, "masked bit differs", 7'h43, 1'b0, 1'b1, 7'h42, 7'h7f, 2, 1'b0, 0, 1'b0);
        add_test(2, "enable low", 7'h42, 1'b0, 1'b0, 7'h42, 7'h7f, 2, 1'b0, 0, 1'b0);
        add_test(3, "read bit", 7'h42, 1'b1, 1'b1, 7'h42, 7'h7f, 1, 1'b0, 0, 1'b0);
        add_test(4, "unmasked bit differs", 7'h41, 1'b0, 1'b1, 7'h42, 7'h7c, 2, 1'b0, 0, 1'b1);
        add_test(5, "stretch", 7'h42, 1'b0, 1'b1, 7'h42, 7'h7f, 4, 1'b0, 150, 1'b1);
        add_test(6, "before repeated start", 7'h42, 1'b0, 1'b1, 7'h42, 7'h7f, 2, 1'b1, 0, 1'b1);
        add_test(7, "after repeated start", 7'h42, 1'b0, 1'b1, 7'h42, 7'h7f, 3, 1'b0, 90, 1'b1);
    endtask

    function automatic int run_limit();
        int bits;
        int stalls;
        bits   = 0;
        stalls = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            // start, address with ACK, data with ACK, stop
            bits   += 2 + 9 * (1 + t_bytes[i]);
            stalls += t_stall[i] * t_bytes[i];
        end
        return bits * 2 * HALF * 2 + stalls;
    endfunction

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    // the target may hold SCL low
    task automatic wait_scl_high();
        while (!scl_bus) @(negedge clk);
    endtask

    // entered with SCL low and hold time done
    task automatic send_bit(input logic b);
        sda_m = b;
        wait_clocks(QUART);
        scl_m = 1'b1;
        wait_scl_high();
        wait_clocks(HALF);
        scl_m = 1'b0;
        wait_clocks(QUART);
    endtask

    task automatic read_ack(output logic ack);
        sda_m = 1'b1;
        wait_clocks(QUART);
        scl_m = 1'b1;
        wait_scl_high();
        wait_clocks(QUART);
        ack = !sda_bus;
        wait_clocks(QUART);
        scl_m = 1'b0;
        wait_clocks(QUART);
    endtask

    task automatic send_byte(input logic [7:0] value, output logic ack);
        // msb first
        for (int i = 7; i >= 0; i--) begin
            send_bit(value[i]);
        end
        read_ack(ack);
    endtask

    // also serves as repeated start when SCL is low
    task automatic bus_start();
        if (!scl_m) begin
            sda_m = 1'b1;
            wait_clocks(QUART);
            scl_m = 1'b1;
            wait_scl_high();
            wait_clocks(HALF);
        end
        sda_m = 1'b0;
        wait_clocks(HALF);
        scl_m = 1'b0;
        wait_clocks(QUART);
    endtask

    task automatic bus_stop();
        sda_m = 1'b0;
        wait_clocks(QUART);
        scl_m = 1'b1;
        wait_scl_high();
        wait_clocks(HALF);
        sda_m = 1'b1;
        wait_clocks(HALF);
    endtask

    task automatic wait_bus_idle();
        int n;
        n = 0;
        // stop reaches bus_active through the filter
        while (bus_active && n < 4 * QUART) begin
            @(negedge clk);
            n++;
        end
    endtask

    // byte moves at the next posedge, m_data is stable here
    task automatic take_byte();
        logic [8:0] exp;
        check("stream byte expected", 1, exp_q.size() != 0);
        exp = exp_q.pop_front();
        check("m_data", exp[7:0], m_data);
        check("m_last", exp[8], m_last);
    endtask

    // stream sink with per-byte stall
    initial begin
        int stall_cnt;
        m_ready   = 1'b0;
        stall_cnt = 0;
        forever begin
            @(negedge clk);
            if (rst) begin
                m_ready = 1'b0;
            end else if (m_valid) begin
                if (stall_cnt >= cur_stall) begin
                    take_byte();
                    m_ready   = 1'b1;
                    stall_cnt = 0;
                end else begin
                    m_ready = 1'b0;
                    stall_cnt++;
                end
            end else begin
                m_ready = (cur_stall == 0);
            end
        end
    end

    // SCL hold watch
    initial begin
        logic valid_prev;
        valid_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (!scl_o) begin
                    stretch_cycles++;
                    // one cycle of lag after the byte is taken
                    check("scl_o low with no waiting byte", 1, valid_prev);
                end
                valid_prev = m_valid;
            end
        end
    end

    task automatic run_test(input int idx);
        logic ack;
        logic last;
        logic [31:0] rnd;
        i2c_target_pkg::byte_t data;
        int stretch_start;
        cur_name            = t_name[idx];
        cur_stall           = t_stall[idx];
        enable              = t_en[idx];
        device_address      = t_dev[idx];
        device_address_mask = t_mask[idx];
        stretch_start       = stretch_cycles;
        bus_start();
        send_byte({t_addr[idx], t_rw[idx]}, ack);
        check("address ack", t_ack[idx], ack);
        check("bus_active", 1, bus_active);
        // a rejected address sends the FSM back to idle
        check("busy", t_ack[idx], busy);
        check("bus_addressed", t_ack[idx], bus_addressed);
        if (t_ack[idx]) begin
            check("bus_address", t_addr[idx], bus_address);
            for (int b = 0; b < t_bytes[idx]; b++) begin
                rnd  = $urandom;
                data = rnd[7:0];
                last = (b == t_bytes[idx] - 1);
                exp_q.push_back({last, data});
                send_byte(data, ack);
                check("data ack", 1, ack);
            end
            if (t_stall[idx] > STRETCH_MIN && t_bytes[idx] > 1) begin
                check("scl stretched", 1, stretch_cycles > stretch_start);
            end
        end
        // with a repeated start the next start flushes the last byte
        if (!t_rs[idx]) begin
            bus_stop();
            wait_bus_idle();
            check("bus_active after stop", 0, bus_active);
            while (exp_q.size() != 0) @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0] seed_val;
        seed_val            = $urandom(76);
        clk                 = 1'b0;
        rst                 = 1'b1;
        scl_m               = 1'b1;
        sda_m               = 1'b1;
        enable              = 1'b0;
        device_address      = '0;
        device_address_mask = '0;
        cur_name            = "reset";
        cur_stall           = 0;
        stretch_cycles      = 0;
        cycles              = 0;
        load_table();
        limit = run_limit();

        wait_clocks(16);
        rst = 1'b0;
        @(negedge clk);
        check("scl_o", 1, scl_o);
        check("sda_o", 1, sda_o);
        check("m_valid", 0, m_valid);
        check("busy", 0, busy);
        check("bus_addressed", 0, bus_addressed);
        check("bus_active", 0, bus_active);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
